//--- Makefile
# Verilator build and run for the FFT input loader

TOOL      := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_fft_loader
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := sim_$(TOP)
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, then search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

# Status comes from the log, not from the simulator exit code
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(SIM_BIN) -f $(FILELIST)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/bitrev_writer.sv
// Sample writer that stores each sample at its bit-reversed index and tracks frame full
`timescale 1ns/1ps

module bitrev_writer import fft_loader_pkg::*; (
   input  logic                       clk,
   input  logic                       rst_n,
   // Sample handshake from the decoder
   input  logic signed [SAMPLE_W-1:0] sample_re_i,
   input  logic signed [SAMPLE_W-1:0] sample_im_i,
   input  logic                       sample_valid_i,
   output logic                       sample_ready_o,
   // Write port into the frame buffer
   output logic                       mem_we_o,
   output logic [ADDR_W-1:0]          mem_addr_o,
   output logic signed [SAMPLE_W-1:0] mem_re_o,
   output logic signed [SAMPLE_W-1:0] mem_im_o,
   // Frame state shared with the buffer
   output logic                       frame_full_o,
   input  logic                       frame_release_i
);

   // Arrival index within the frame
   logic [ADDR_W-1:0] count;
   logic [ADDR_W-1:0] count_rev;
   logic              take;
   logic              last;

   // Refuse samples while the host owns the frame
   assign sample_ready_o = ~frame_full_o;
   assign take           = sample_valid_i & sample_ready_o;
   assign last           = (count == ADDR_W'(N_POINTS - 1));

   // Mirror the index bits into DIT input order
   always_comb begin
      for (int i = 0; i < ADDR_W; i++) begin
         count_rev[i] = count[ADDR_W-1-i];
      end
   end

   // --------------------------------------------------
   // Counter, write strobe and frame state
   // --------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count        <= '0;
         mem_we_o     <= 1'b0;
         frame_full_o <= 1'b0;
      end else begin
         mem_we_o <= take;
         if (take) begin
            // Wraps to 0 after entry 15
            count <= count + 1'b1;
         end
         // Full as soon as the last entry is accepted
         if (take && last) begin
            frame_full_o <= 1'b1;
         end else if (frame_release_i) begin
            frame_full_o <= 1'b0;
         end
      end
   end

   // Address and data for the write one cycle later
   always_ff @(posedge clk) begin
      if (take) begin
         mem_addr_o <= count_rev;
         mem_re_o   <= sample_re_i;
         mem_im_o   <= sample_im_i;
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------

   // Only the write that completes the frame overlaps frame full
   a_no_write_full : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_we_o && frame_full_o |-> $rose(frame_full_o) && (mem_addr_o == '1)
   );

endmodule

//--- logic/fft_loader_pkg.sv
// FFT loader shared constants: frame size, sample widths and Wishbone register map
package fft_loader_pkg;

   // --------------------------------------------------
   // Frame geometry
   // --------------------------------------------------

   // Samples per frame, one radix-2 frame of 16 points
   localparam int N_POINTS = 16;

   // Sample index width, log2 of N_POINTS
   localparam int ADDR_W = 4;

   // One real or imaginary part
   // Layout: 8 sign bits, the input byte, 8 zero bits
   localparam int SAMPLE_W = 24;

   // --------------------------------------------------
   // Wishbone register map
   // --------------------------------------------------

   // Word address width and data width of the slave port
   localparam int WB_ADR_W = 6;
   localparam int WB_DAT_W = 32;

   // Real parts, words 0 to 15
   localparam int RE_BASE = 0;

   // Imaginary parts, words 16 to 31
   localparam int IM_BASE = 16;

   // Status word
   // Bit 0 reads frame full, any write releases the frame
   localparam int STATUS_ADR = 32;

endpackage

//--- logic/fft_loader_top.sv
// FFT input loader top: byte decoder, bit-reversing writer and Wishbone frame buffer
`timescale 1ns/1ps

module fft_loader_top import fft_loader_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   // Byte stream, e.g. from a UART receiver
   input  logic [7:0]          byte_i,
   input  logic                byte_valid_i,
   output logic                byte_ready_o,
   // Wishbone classic slave
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [WB_ADR_W-1:0] wb_adr_i,
   input  logic [WB_DAT_W-1:0] wb_dat_i,
   output logic [WB_DAT_W-1:0] wb_dat_o,
   output logic                wb_ack_o
);

   // Decoder to writer
   logic signed [SAMPLE_W-1:0] sample_re;
   logic signed [SAMPLE_W-1:0] sample_im;
   logic                       sample_valid;
   logic                       sample_ready;

   // Writer to buffer
   logic                       mem_we;
   logic [ADDR_W-1:0]          mem_addr;
   logic signed [SAMPLE_W-1:0] mem_re;
   logic signed [SAMPLE_W-1:0] mem_im;
   logic                       frame_full;
   logic                       frame_release;

   // --------------------------------------------------
   // Decode
   // --------------------------------------------------

   sample_decoder u_decoder (
      .clk            (clk),
      .rst_n          (rst_n),
      .byte_i         (byte_i),
      .byte_valid_i   (byte_valid_i),
      .byte_ready_o   (byte_ready_o),
      .sample_re_o    (sample_re),
      .sample_im_o    (sample_im),
      .sample_valid_o (sample_valid),
      .sample_ready_i (sample_ready)
   );

   // --------------------------------------------------
   // Execute
   // --------------------------------------------------

   bitrev_writer u_writer (
      .clk             (clk),
      .rst_n           (rst_n),
      .sample_re_i     (sample_re),
      .sample_im_i     (sample_im),
      .sample_valid_i  (sample_valid),
      .sample_ready_o  (sample_ready),
      .mem_we_o        (mem_we),
      .mem_addr_o      (mem_addr),
      .mem_re_o        (mem_re),
      .mem_im_o        (mem_im),
      .frame_full_o    (frame_full),
      .frame_release_i (frame_release)
   );

   // --------------------------------------------------
   // Result
   // --------------------------------------------------

   frame_buffer u_buffer (
      .clk             (clk),
      .rst_n           (rst_n),
      .mem_we_i        (mem_we),
      .mem_addr_i      (mem_addr),
      .mem_re_i        (mem_re),
      .mem_im_i        (mem_im),
      .frame_full_i    (frame_full),
      .frame_release_o (frame_release),
      .wb_cyc_i        (wb_cyc_i),
      .wb_stb_i        (wb_stb_i),
      .wb_we_i         (wb_we_i),
      .wb_adr_i        (wb_adr_i),
      .wb_dat_i        (wb_dat_i),
      .wb_dat_o        (wb_dat_o),
      .wb_ack_o        (wb_ack_o)
   );

endmodule

//--- logic/frame_buffer.sv
// Frame buffer holding one FFT input frame behind a Wishbone classic read port
`timescale 1ns/1ps

module frame_buffer import fft_loader_pkg::*; (
   input  logic                       clk,
   input  logic                       rst_n,
   // Write port from the bit-reversing writer
   input  logic                       mem_we_i,
   input  logic [ADDR_W-1:0]          mem_addr_i,
   input  logic signed [SAMPLE_W-1:0] mem_re_i,
   input  logic signed [SAMPLE_W-1:0] mem_im_i,
   input  logic                       frame_full_i,
   output logic                       frame_release_o,
   // Wishbone classic slave
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [WB_ADR_W-1:0]        wb_adr_i,
   input  logic [WB_DAT_W-1:0]        wb_dat_i,
   output logic [WB_DAT_W-1:0]        wb_dat_o,
   output logic                       wb_ack_o
);

   // Real and imaginary parts in bit-reversed order
   logic signed [SAMPLE_W-1:0] re_mem [N_POINTS];
   logic signed [SAMPLE_W-1:0] im_mem [N_POINTS];

   logic                req;
   logic                sel_re;
   logic                sel_im;
   logic                sel_status;
   logic [ADDR_W-1:0]   word_idx;
   logic [WB_DAT_W-1:0] rd_data;

   // --------------------------------------------------
   // Sample memory
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (mem_we_i) begin
         re_mem[mem_addr_i] <= mem_re_i;
         im_mem[mem_addr_i] <= mem_im_i;
      end
   end

   // --------------------------------------------------
   // Address decode and read mux
   // --------------------------------------------------

   // New access is masked during the ack cycle so ack lasts one cycle
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   assign sel_re     = (wb_adr_i < WB_ADR_W'(RE_BASE + N_POINTS));
   assign sel_im     = (wb_adr_i >= WB_ADR_W'(IM_BASE)) &&
                       (wb_adr_i < WB_ADR_W'(IM_BASE + N_POINTS));
   assign sel_status = (wb_adr_i == WB_ADR_W'(STATUS_ADR));

   // Both bases sit on 16-word boundaries
   assign word_idx = wb_adr_i[ADDR_W-1:0];

   always_comb begin
      rd_data = '0;
      if (sel_re) begin
         rd_data = {{(WB_DAT_W-SAMPLE_W){re_mem[word_idx][SAMPLE_W-1]}}, re_mem[word_idx]};
      end else if (sel_im) begin
         rd_data = {{(WB_DAT_W-SAMPLE_W){im_mem[word_idx][SAMPLE_W-1]}}, im_mem[word_idx]};
      end else if (sel_status) begin
         rd_data[0] = frame_full_i;
      end
      // Unmapped words read as zero
   end

   // --------------------------------------------------
   // Bus response and release strobe
   // --------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack_o        <= 1'b0;
         frame_release_o <= 1'b0;
      end else begin
         wb_ack_o        <= req;
         // One-cycle pulse that ignores the written value
         frame_release_o <= req & wb_we_i & sel_status;
      end
   end

   // Read data latched with the request
   always_ff @(posedge clk) begin
      if (req && !wb_we_i) begin
         wb_dat_o <= rd_data;
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------

   // Ack only answers a request the master still holds
   a_ack_in_cycle : assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_ack_o |-> wb_cyc_i && wb_stb_i
   );

   // Master drives known data on every write including status
   a_wdata_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_cyc_i && wb_stb_i && wb_we_i |-> !$isunknown(wb_dat_i)
   );

endmodule

//--- logic/sample_decoder.sv
// Byte-pair decoder that turns a signed byte stream into scaled complex samples
`timescale 1ns/1ps

module sample_decoder import fft_loader_pkg::*; (
   input  logic                       clk,
   input  logic                       rst_n,
   // Byte stream from the source
   input  logic [7:0]                 byte_i,
   input  logic                       byte_valid_i,
   output logic                       byte_ready_o,
   // Sample handshake towards the writer
   output logic signed [SAMPLE_W-1:0] sample_re_o,
   output logic signed [SAMPLE_W-1:0] sample_im_o,
   output logic                       sample_valid_o,
   input  logic                       sample_ready_i
);

   // Phase of the byte pair: low waits for real, high waits for imaginary
   logic                       phase_im;
   // Real part parked until its partner byte arrives
   logic signed [SAMPLE_W-1:0] re_hold;
   logic                       byte_take;
   logic                       sample_take;

   // Byte times 256, sign-extended to the sample width
   function automatic logic signed [SAMPLE_W-1:0] scale_byte(input logic [7:0] b);
      scale_byte = {{(SAMPLE_W-16){b[7]}}, b, 8'h00};
   endfunction

   // --------------------------------------------------
   // Handshakes
   // --------------------------------------------------

   // Stall only while a finished sample still waits for the writer
   assign byte_ready_o = ~(sample_valid_o & ~sample_ready_i);
   assign byte_take    = byte_valid_i & byte_ready_o;
   assign sample_take  = sample_valid_o & sample_ready_i;

   // --------------------------------------------------
   // Pair phase and valid flag
   // --------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase_im       <= 1'b0;
         sample_valid_o <= 1'b0;
      end else begin
         if (byte_take) begin
            phase_im <= ~phase_im;
         end
         // New sample on the imaginary byte, even in the handoff cycle
         if (byte_take && phase_im) begin
            sample_valid_o <= 1'b1;
         end else if (sample_take) begin
            sample_valid_o <= 1'b0;
         end
      end
   end

   // --------------------------------------------------
   // Payload registers
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (byte_take && !phase_im) begin
         re_hold <= scale_byte(byte_i);
      end
      // Both parts move into the holding register together
      if (byte_take && phase_im) begin
         sample_re_o <= re_hold;
         sample_im_o <= scale_byte(byte_i);
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------

   // A stalled sample keeps its data until the writer takes it
   a_hold_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      sample_valid_o && !sample_ready_i |=>
         $stable(sample_re_o) && $stable(sample_im_o) && sample_valid_o
   );

endmodule

//--- sim.f
logic/fft_loader_pkg.sv
logic/sample_decoder.sv
logic/bitrev_writer.sv
logic/frame_buffer.sv
logic/fft_loader_top.sv
testbench/tb_clock_gen.sv
testbench/tb_fft_loader.sv

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source with a 10 ns clock and a 16-cycle active-low reset
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   // 10 ns period
   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 16;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   // Release just after an edge, away from the flops' sampling point
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

//--- testbench/tb_fft_loader.sv
// Testbench for the FFT input loader that checks random byte frames against a bit-reversed model
`timescale 1ns/1ps

module tb_fft_loader import fft_loader_pkg::*; ();

   localparam logic [31:0] SEED = 32'h8282_288d;
   // Per-access wait for ack
   localparam int ACK_LIMIT = 4;
   // 4 frames of 32 bytes plus 4 x 33 bus accesses, 4 cycles each, doubled, plus reset
   localparam int BYTE_CYCLES = 4 * 32 * 4;
   localparam int BUS_CYCLES  = 4 * 33 * 4;
   localparam int CYCLE_LIMIT = 2 * (BYTE_CYCLES + BUS_CYCLES) + 16;

   logic                clk;
   logic                rst_n;
   logic [7:0]          byte_i;
   logic                byte_valid_i;
   logic                byte_ready_o;
   logic                wb_cyc_i;
   logic                wb_stb_i;
   logic                wb_we_i;
   logic [WB_ADR_W-1:0] wb_adr_i;
   logic [WB_DAT_W-1:0] wb_dat_i;
   logic [WB_DAT_W-1:0] wb_dat_o;
   logic                wb_ack_o;

   // Model: every accepted byte in arrival order, frame start at the front
   logic [7:0] byte_q [$];
   string      cur_test;
   int         err_count    = 0;
   int         err_base     = 0;
   int         tests_run    = 0;
   int         tests_failed = 0;
   int         cycle_count  = 0;

   tb_clock_gen u_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   fft_loader_top DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .byte_i       (byte_i),
      .byte_valid_i (byte_valid_i),
      .byte_ready_o (byte_ready_o),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o)
   );

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: run stopped after %0d cycles", cycle_count);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // --------------------------------------------------
   // Model helpers
   // --------------------------------------------------

   // Mirror the 4 index bits
   function automatic int reverse_index(input int k);
      int r;
      r = 0;
      for (int i = 0; i < ADDR_W; i++) begin
         r = r | (((k >> i) & 1) << (ADDR_W - 1 - i));
      end
      return r;
   endfunction

   // Signed byte times 256 as a 32-bit bus word
   function automatic logic [WB_DAT_W-1:0] expected_word(input logic [7:0] b);
      int v;
      v = int'($signed(b));
      return WB_DAT_W'(v * 256);
   endfunction

   // --------------------------------------------------
   // Timing and byte stream
   // --------------------------------------------------

   // Every task starts and ends 1 ns after a rising edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         tick();
      end
   endtask

   // Ready comes from flops, so its value now holds at the next edge
   task automatic offer_byte(input logic [7:0] b, input int max_wait, output logic taken);
      int waited;
      taken        = 1'b0;
      waited       = 0;
      byte_i       = b;
      byte_valid_i = 1'b1;
      while (!taken && waited < max_wait) begin
         taken = byte_ready_o;
         tick();
         waited++;
      end
      byte_valid_i = 1'b0;
      if (taken) begin
         byte_q.push_back(b);
      end
   endtask

   task automatic send_bytes(input int n);
      logic [7:0] b;
      logic       taken;
      for (int i = 0; i < n; i++) begin
         idle_cycles(int'($urandom_range(3, 0)));
         b = 8'($urandom);
         offer_byte(b, 16, taken);
         assert (taken) else begin
            $display("%s: byte %h not accepted within 16 cycles", cur_test, b);
            err_count++;
         end
      end
   endtask

   // --------------------------------------------------
   // Wishbone master
   // --------------------------------------------------

   task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] wdata,
                            output logic [WB_DAT_W-1:0] rdata);
      int   waited;
      logic acked;
      waited   = 0;
      acked    = 1'b0;
      rdata    = '0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdata;
      while (!acked && waited < ACK_LIMIT) begin
         tick();
         waited++;
         acked = wb_ack_o;
      end
      assert (acked) else begin
         $display("%s: no ack for word %0d within %0d cycles", cur_test, adr, ACK_LIMIT);
         err_count++;
      end
      assert (!acked || waited == 1) else begin
         $display("Mismatch %s ack latency word %0d: expected 1, actual %0d",
                  cur_test, adr, waited);
         err_count++;
      end
      if (acked) begin
         rdata = wb_dat_o;
         // Strobe stays up through the edge that samples ack
         tick();
         assert (!wb_ack_o) else begin
            $display("%s: ack for word %0d held longer than one cycle", cur_test, adr);
            err_count++;
         end
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_dat_i = '0;
      tick();
   endtask

   task automatic read_check(input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] exp, input string what);
      logic [WB_DAT_W-1:0] got;
      wb_access(1'b0, adr, '0, got);
      assert (got == exp) else begin
         $display("Mismatch %s %s word %0d: expected %h, actual %h",
                  cur_test, what, adr, exp, got);
         err_count++;
      end
   endtask

   // Last write lands a few cycles after the last byte
   task automatic wait_frame_full();
      logic [WB_DAT_W-1:0] status;
      int                  tries;
      status = '0;
      tries  = 0;
      while (status[0] !== 1'b1 && tries < 8) begin
         wb_access(1'b0, WB_ADR_W'(STATUS_ADR), '0, status);
         tries++;
      end
      assert (status[0] === 1'b1) else begin
         $display("%s: frame full not reported after %0d status reads", cur_test, tries);
         err_count++;
      end
   endtask

   // Word k holds the sample whose arrival index reversed is k
   task automatic check_frame(input logic gaps);
      int a;
      assert (byte_q.size() >= 2 * N_POINTS) else begin
         $display("%s: model holds only %0d bytes", cur_test, byte_q.size());
         err_count++;
         return;
      end
      for (int k = 0; k < N_POINTS; k++) begin
         a = reverse_index(k);
         if (gaps) idle_cycles(int'($urandom_range(3, 0)));
         read_check(WB_ADR_W'(RE_BASE + k), expected_word(byte_q[2 * a]), "real");
         if (gaps) idle_cycles(int'($urandom_range(3, 0)));
         read_check(WB_ADR_W'(IM_BASE + k), expected_word(byte_q[2 * a + 1]), "imag");
      end
   endtask

   // Any write value releases, the model drops the frame's bytes
   task automatic release_frame();
      logic [WB_DAT_W-1:0] unused_rd;
      wb_access(1'b1, WB_ADR_W'(STATUS_ADR), $urandom, unused_rd);
      for (int i = 0; i < 2 * N_POINTS; i++) begin
         void'(byte_q.pop_front());
      end
      read_check(WB_ADR_W'(STATUS_ADR), '0, "status after release");
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err_base = err_count;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_count == err_base) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, err_count - err_base);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      logic                taken;
      int                  taken_count;
      logic [WB_ADR_W-1:0] adr;
      byte_i       = '0;
      byte_valid_i = 1'b0;
      wb_cyc_i     = 1'b0;
      wb_stb_i     = 1'b0;
      wb_we_i      = 1'b0;
      wb_adr_i     = '0;
      wb_dat_i     = '0;
      void'($urandom(SEED));
      wait (rst_n === 1'b1);
      tick();

      begin_test("reset_state");
      assert (byte_ready_o === 1'b1) else begin
         $display("Mismatch %s byte_ready_o: expected 1, actual %b", cur_test, byte_ready_o);
         err_count++;
      end
      read_check(WB_ADR_W'(STATUS_ADR), '0, "status");
      end_test();

      begin_test("full_frame");
      send_bytes(2 * N_POINTS);
      wait_frame_full();
      check_frame(1'b0);
      end_test();

      // Decoder may take one more pair, then must stall
      begin_test("back_pressure");
      taken_count = 0;
      for (int i = 0; i < 3; i++) begin
         offer_byte(8'($urandom), 4, taken);
         if (taken) taken_count++;
      end
      assert (taken_count <= 2) else begin
         $display("Mismatch %s bytes taken while full: expected at most 2, actual %0d",
                  cur_test, taken_count);
         err_count++;
      end
      assert (!byte_ready_o) else begin
         $display("%s: byte_ready_o still high with the frame full", cur_test);
         err_count++;
      end
      check_frame(1'b0);
      end_test();

      // Waiting sample becomes arrival 0 of the next frame
      begin_test("release_carry");
      release_frame();
      send_bytes(2 * N_POINTS - byte_q.size());
      wait_frame_full();
      check_frame(1'b0);
      end_test();

      begin_test("unmapped_random");
      for (int i = 0; i < 4; i++) begin
         adr = WB_ADR_W'($urandom_range(2 ** WB_ADR_W - 1, STATUS_ADR + 1));
         read_check(adr, '0, "unmapped");
      end
      for (int f = 0; f < 2; f++) begin
         release_frame();
         send_bytes(2 * N_POINTS);
         wait_frame_full();
         check_frame(1'b1);
      end
      end_test();

      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
